// ==== hdl/rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath and address width of the RV32I core
`define RV_XLEN 32

// register index width
`define RV_REG_ADDR_W 5

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  // alu operations, pass_b forwards operand b for lui
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // branch compare, encoded as the branch funct3
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_e;

  // store access size
  typedef enum logic [1:0] {
    st_byte = 2'd0,
    st_half = 2'd1,
    st_word = 2'd2
  } store_size_e;

endpackage

`default_nettype wire

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      we,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  input  logic [`RV_XLEN-1:0]       rd_data,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // two asynchronous read ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 is cleared by reset and never written, so it always reads zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_decoder (
  input  logic [`RV_XLEN-1:0]       insn,
  output logic [`RV_REG_ADDR_W-1:0] rd,
  output logic [`RV_REG_ADDR_W-1:0] rs1,
  output logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]       imm,
  output rv_pkg::alu_op_e           alu_op,
  output logic                      a_is_pc,
  output logic                      b_is_imm,
  output logic                      reg_write,
  output logic                      branch,
  output logic                      jal,
  output logic                      jalr,
  output logic                      store,
  output logic                      halt,
  output rv_pkg::branch_e           branch_kind,
  output rv_pkg::store_size_e       store_size
);

  import rv_pkg::*;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;

  // fixed field positions shared by all formats
  assign opcode = opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // sign-extended immediates, one per format
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_s = {{(`RV_XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25],
                  insn[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20],
                  insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // funct3 of a branch is the compare kind itself
  assign branch_kind = branch_e'(funct3);

  always_comb begin
    imm        = imm_i;
    alu_op     = alu_add;
    a_is_pc    = 1'b0;
    b_is_imm   = 1'b0;
    reg_write  = 1'b0;
    branch     = 1'b0;
    jal        = 1'b0;
    jalr       = 1'b0;
    store      = 1'b0;
    halt       = 1'b0;
    store_size = st_word;

    case (opcode)
      opc_lui: begin
        imm       = imm_u;
        b_is_imm  = 1'b1;
        alu_op    = alu_pass_b;
        reg_write = 1'b1;
      end
      opc_auipc: begin
        imm       = imm_u;
        a_is_pc   = 1'b1;
        b_is_imm  = 1'b1;
        reg_write = 1'b1;
      end
      opc_jal: begin
        imm       = imm_j;
        jal       = 1'b1;
        reg_write = 1'b1;
      end
      opc_jalr: begin
        // target is rs1 + imm from the alu
        b_is_imm  = 1'b1;
        jalr      = (funct3 == 3'b000);
        reg_write = (funct3 == 3'b000);
      end
      opc_branch: begin
        imm    = imm_b;
        branch = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      opc_store: begin
        imm      = imm_s;
        b_is_imm = 1'b1;
        case (funct3)
          3'b000:  store_size = st_byte;
          3'b001:  store_size = st_half;
          default: store_size = st_word;
        endcase
        store = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
      end
      opc_op_imm: begin
        b_is_imm  = 1'b1;
        reg_write = 1'b1;
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b110: alu_op = alu_or;
          3'b111: alu_op = alu_and;
          3'b001: begin
            alu_op    = alu_sll;
            reg_write = (funct7 == funct7_base);
          end
          default: begin
            // srli or srai picked by funct7, shamt sits in imm[4:0]
            alu_op    = (funct7 == funct7_alt) ? alu_sra : alu_srl;
            reg_write = (funct7 == funct7_base) || (funct7 == funct7_alt);
          end
        endcase
      end
      opc_op: begin
        case (funct3)
          3'b000:  alu_op = (funct7 == funct7_alt) ? alu_sub : alu_add;
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b011:  alu_op = alu_sltu;
          3'b100:  alu_op = alu_xor;
          3'b101:  alu_op = (funct7 == funct7_alt) ? alu_sra : alu_srl;
          3'b110:  alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
        // the alternate funct7 only exists for sub and sra
        reg_write = (funct7 == funct7_base) ||
                    ((funct7 == funct7_alt) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      opc_system: begin
        // only ecall is recognised here
        halt = (insn[31:7] == '0);
      end
      default: begin
        // out of scope encodings fall through as a no-op
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_alu (
  input  rv_pkg::alu_op_e     op,
  input  rv_pkg::branch_e     branch_kind,
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  output logic [`RV_XLEN-1:0] result,
  output logic                cond
);

  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign shamt = b[4:0];

  // compare results shared by slt, sltu and the branches
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;
  assign equal       = (a == b);

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $signed(a) >>> shamt;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // branch condition, only meaningful while a branch is decoded
  always_comb begin
    case (branch_kind)
      br_eq:   cond = equal;
      br_ne:   cond = !equal;
      br_lt:   cond = lt_signed;
      br_ge:   cond = !lt_signed;
      br_ltu:  cond = lt_unsigned;
      br_geu:  cond = !lt_unsigned;
      default: cond = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rv_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_pc_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                branch,
  input  logic                cond,
  input  logic                jal,
  input  logic                jalr,
  input  logic                halt,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] jump_target,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] pc_plus4
);

  logic [`RV_XLEN-1:0] pc_rel;
  logic [`RV_XLEN-1:0] pc_next;

  assign pc_plus4 = pc + `RV_XLEN'd4;

  // pc relative target for jal and taken branches
  assign pc_rel = pc + imm;

  always_comb begin
    if (jalr) begin
      // jalr clears bit 0 of rs1 + imm
      pc_next = {jump_target[`RV_XLEN-1:1], 1'b0};
    end else if (jal || (branch && cond)) begin
      pc_next = pc_rel;
    end else if (halt) begin
      pc_next = pc;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  input  logic [`RV_XLEN-1:0] insn,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] store_addr,
  output logic [`RV_XLEN-1:0] store_data,
  output logic [3:0]          store_we,
  output logic                halt
);

  import rv_pkg::*;

  logic [`RV_REG_ADDR_W-1:0] rd;
  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;
  logic [`RV_XLEN-1:0]       wb_data;
  logic [`RV_XLEN-1:0]       imm;
  logic [`RV_XLEN-1:0]       alu_a;
  logic [`RV_XLEN-1:0]       alu_b;
  logic [`RV_XLEN-1:0]       alu_result;
  logic [`RV_XLEN-1:0]       pc_plus4;
  alu_op_e                   alu_op;
  branch_e                   branch_kind;
  store_size_e               store_size;
  logic                      a_is_pc;
  logic                      b_is_imm;
  logic                      reg_write;
  logic                      branch;
  logic                      jal;
  logic                      jalr;
  logic                      store;
  logic                      cond;

  rv_decoder i_decoder (
    .insn        (insn),
    .rd          (rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .imm         (imm),
    .alu_op      (alu_op),
    .a_is_pc     (a_is_pc),
    .b_is_imm    (b_is_imm),
    .reg_write   (reg_write),
    .branch      (branch),
    .jal         (jal),
    .jalr        (jalr),
    .store       (store),
    .halt        (halt),
    .branch_kind (branch_kind),
    .store_size  (store_size)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_write),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // operand muxes, auipc takes the pc as a
  assign alu_a = a_is_pc ? pc : rs1_data;
  assign alu_b = b_is_imm ? imm : rs2_data;

  rv_alu i_alu (
    .op          (alu_op),
    .branch_kind (branch_kind),
    .a           (alu_a),
    .b           (alu_b),
    .result      (alu_result),
    .cond        (cond)
  );

  rv_pc_unit i_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .branch      (branch),
    .cond        (cond),
    .jal         (jal),
    .jalr        (jalr),
    .halt        (halt),
    .imm         (imm),
    .jump_target (alu_result),
    .pc          (pc),
    .pc_plus4    (pc_plus4)
  );

  // jumps link the return address
  assign wb_data = (jal || jalr) ? pc_plus4 : alu_result;

  // store address is rs1 + imm out of the alu, the word part goes out
  assign store_addr = {alu_result[`RV_XLEN-1:2], 2'b00};

  always_comb begin
    case (store_size)
      st_byte: begin
        store_we   = 4'b0001 << alu_result[1:0];
        store_data = {4{rs2_data[7:0]}};
      end
      st_half: begin
        store_we   = alu_result[1] ? 4'b1100 : 4'b0011;
        store_data = {2{rs2_data[15:0]}};
      end
      default: begin
        store_we   = 4'b1111;
        store_data = rs2_data;
      end
    endcase
    if (!store) begin
      store_we = 4'b0000;
    end
  end

endmodule

`default_nettype wire

// ==== verification/rv_core_programs.svh ====
`ifndef RV_CORE_PROGRAMS_SVH
`define RV_CORE_PROGRAMS_SVH

  localparam logic [6:0] opc_imm   = 7'b0010011;
  localparam logic [6:0] opc_lui   = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jalr  = 7'b1100111;

  string      imm_names [9]  = '{"addi", "slti", "sltiu", "xori", "ori", "andi",
                                 "slli", "srli", "srai"};
  logic [2:0] imm_f3    [9]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
  string      reg_names [10] = '{"add", "sub", "sll", "slt", "sltu", "xor", "srl", "sra",
                                 "or", "and"};
  logic [2:0] reg_f3    [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  string      br_names  [6]  = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
  logic [2:0] br_f3     [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  // one encoder per instruction format
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] upper, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {upper, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic begin_test(input string name);
    test_name[num_tests] = name;
    prog_len[num_tests]  = 0;
    exp_count[num_tests] = 0;
    exp_halt[num_tests]  = -1;
  endtask

  task automatic emit(input logic [31:0] word);
    prog[num_tests][prog_len[num_tests]] = word;
    prog_len[num_tests]++;
  endtask

  // an explicit ecall fixes where the core has to stop
  task automatic emit_ecall();
    exp_halt[num_tests] = 4 * prog_len[num_tests];
    emit(ecall_word);
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [3:0] we,
                              input logic [31:0] data);
    exp_addr[num_tests][exp_count[num_tests]] = addr;
    exp_we[num_tests][exp_count[num_tests]]   = we;
    exp_data[num_tests][exp_count[num_tests]] = data;
    exp_count[num_tests]++;
  endtask

  // otherwise the core stops on the ecall served past the last word
  task automatic end_test();
    if (exp_halt[num_tests] < 0) begin
      exp_halt[num_tests] = 4 * prog_len[num_tests];
    end
    num_tests++;
  endtask

  // lui plus addi, upper part rounded up when the low half is negative
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h0000_0800;
    emit(enc_u(hi[31:12], rd, opc_lui));
    emit(enc_i(value[11:0], rd, 3'b000, rd, opc_imm));
  endtask

  task automatic store_word(input logic [4:0] rs2, input logic [11:0] offset);
    emit(enc_s(offset, rs2, 5'd0, 3'b010));
  endtask

  task automatic build_programs();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] neg;
    logic [31:0] pos;
    logic [11:0] imm;
    logic        alt;
    logic        taken;

    // full words through lui and addi, plus a negative immediate
    for (int k = 0; k < 2; k++) begin
      a = next_rand();
      begin_test($sformatf("lui_addi_%0d", k));
      load_reg(5'd1, a);
      emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, opc_imm));
      store_word(5'd1, 12'd0);
      store_word(5'd2, 12'd4);
      expect_store(32'd0, 4'hf, a);
      expect_store(32'd4, 4'hf, 32'hffff_fffd);
      end_test();
    end

    for (int i = 0; i < 9; i++) begin
      a   = next_rand();
      r   = next_rand();
      alt = (i == 8);
      if ((imm_f3[i] == 3'b001) || (imm_f3[i] == 3'b101)) begin
        // shamt in the low bits, srai sets bit 10
        imm = {1'b0, alt, 5'b00000, r[4:0]};
        b   = {27'd0, r[4:0]};
      end else begin
        imm = r[11:0];
        b   = {{20{imm[11]}}, imm};
      end
      begin_test(imm_names[i]);
      load_reg(5'd1, a);
      emit(enc_i(imm, 5'd1, imm_f3[i], 5'd2, opc_imm));
      store_word(5'd2, 12'd8);
      expect_store(32'd8, 4'hf, ref_alu(imm_f3[i], alt, a, b));
      end_test();
    end

    for (int i = 0; i < 10; i++) begin
      a   = next_rand();
      b   = next_rand();
      alt = (i == 1) || (i == 7);
      begin_test(reg_names[i]);
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      emit(enc_r({1'b0, alt, 5'b00000}, 5'd2, 5'd1, reg_f3[i], 5'd3));
      store_word(5'd3, 12'd12);
      expect_store(32'd12, 4'hf, ref_alu(reg_f3[i], alt, a, b));
      end_test();
    end

    // operand pairs chosen so every branch sees both outcomes
    for (int i = 0; i < 6; i++) begin
      for (int p = 0; p < 2; p++) begin
        neg = next_rand() | 32'h8000_0000;
        pos = next_rand() & 32'h7fff_ffff;
        if (i < 2) begin
          a = neg;
          b = (p == 0) ? neg : pos;
        end else begin
          a = (p == 0) ? neg : pos;
          b = (p == 0) ? pos : neg;
        end
        taken = ref_branch(br_f3[i], a, b);
        begin_test($sformatf("%s_%s", br_names[i], taken ? "taken" : "not_taken"));
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd3, opc_imm));
        emit(enc_b(13'd8, 5'd1, 5'd2, br_f3[i]));
        // marker in the branch shadow
        emit(enc_i(12'd2, 5'd0, 3'b000, 5'd3, opc_imm));
        store_word(5'd3, 12'd16);
        expect_store(32'd16, 4'hf, taken ? 32'd1 : 32'd2);
        end_test();
      end
    end

    begin_test("jal");
    emit(nop_word);
    emit(enc_j(21'd8, 5'd1));
    emit(enc_i(12'd7, 5'd0, 3'b000, 5'd5, opc_imm));
    store_word(5'd1, 12'd0);
    store_word(5'd5, 12'd4);
    expect_store(32'd0, 4'hf, 32'd8);
    expect_store(32'd4, 4'hf, 32'd0);
    end_test();

    // target 17 lands on 16 once bit 0 is cleared
    begin_test("jalr");
    emit(enc_i(12'd17, 5'd0, 3'b000, 5'd2, opc_imm));
    emit(enc_i(12'd0, 5'd2, 3'b000, 5'd1, opc_jalr));
    emit(enc_i(12'd7, 5'd0, 3'b000, 5'd5, opc_imm));
    emit(enc_i(12'd9, 5'd0, 3'b000, 5'd5, opc_imm));
    store_word(5'd1, 12'd0);
    store_word(5'd5, 12'd4);
    expect_store(32'd0, 4'hf, 32'd8);
    expect_store(32'd4, 4'hf, 32'd0);
    end_test();

    r = next_rand();
    begin_test("auipc");
    emit(nop_word);
    emit(nop_word);
    emit(enc_u(r[19:0], 5'd1, opc_auipc));
    store_word(5'd1, 12'd20);
    expect_store(32'd20, 4'hf, 32'd8 + {r[19:0], 12'h000});
    end_test();

    a = next_rand();
    begin_test("sb_lanes");
    load_reg(5'd1, a);
    emit(enc_i(12'h040, 5'd0, 3'b000, 5'd2, opc_imm));
    for (int k = 0; k < 4; k++) begin
      emit(enc_s(12'(k), 5'd1, 5'd2, 3'b000));
      expect_store(32'h40, 4'b0001 << k, {4{a[7:0]}});
    end
    end_test();

    a = next_rand();
    begin_test("sh_lanes");
    load_reg(5'd1, a);
    emit(enc_i(12'h044, 5'd0, 3'b000, 5'd2, opc_imm));
    emit(enc_s(12'd0, 5'd1, 5'd2, 3'b001));
    emit(enc_s(12'd2, 5'd1, 5'd2, 3'b001));
    expect_store(32'h44, 4'b0011, {2{a[15:0]}});
    expect_store(32'h44, 4'b1100, {2{a[15:0]}});
    end_test();

    begin_test("x0_writes");
    emit(enc_i(12'd5, 5'd0, 3'b000, 5'd0, opc_imm));
    emit(enc_u(20'h12345, 5'd0, opc_lui));
    emit(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd3));
    store_word(5'd0, 12'd0);
    store_word(5'd3, 12'd4);
    expect_store(32'd0, 4'hf, 32'd0);
    expect_store(32'd4, 4'hf, 32'd0);
    end_test();

    // mul, a custom opcode and a bad slli funct7 all aimed at x1
    begin_test("illegal_noop");
    emit(enc_i(12'h055, 5'd0, 3'b000, 5'd1, opc_imm));
    store_word(5'd1, 12'd0);
    emit(enc_r(7'b0000001, 5'd1, 5'd1, 3'b000, 5'd1));
    emit(32'h0000_008b);
    emit(enc_i({7'b0100000, 5'd1}, 5'd1, 3'b001, 5'd1, opc_imm));
    store_word(5'd1, 12'd4);
    expect_store(32'd0, 4'hf, 32'h55);
    expect_store(32'd4, 4'hf, 32'h55);
    end_test();

    begin_test("ecall_halt");
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd1, opc_imm));
    emit_ecall();
    store_word(5'd1, 12'd0);
    end_test();
  endtask

`endif

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_tb;

  localparam int          clk_period  = 4;
  localparam int          timeout_cyc = 200;
  localparam int          max_tests   = 48;
  localparam int          max_insns   = 12;
  localparam int          max_stores  = 8;
  localparam logic [31:0] nop_word    = 32'h0000_0013;
  localparam logic [31:0] ecall_word  = 32'h0000_0073;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] insn;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] store_addr;
  logic [`RV_XLEN-1:0] store_data;
  logic [3:0]          store_we;
  logic                halt;

  // stimulus table and expected stores, one row per test
  string       test_name [max_tests];
  logic [31:0] prog      [max_tests][max_insns];
  int          prog_len  [max_tests];
  int          exp_halt  [max_tests];
  logic [31:0] exp_addr  [max_tests][max_stores];
  logic [3:0]  exp_we    [max_tests][max_stores];
  logic [31:0] exp_data  [max_tests][max_stores];
  int          exp_count [max_tests];
  int          num_tests;

  logic [31:0] cap_addr [$];
  logic [3:0]  cap_we   [$];
  logic [31:0] cap_data [$];

  logic [31:0] rng_state;
  logic        serving  = 1'b0;
  int          cur_test = 0;
  int          fetch_idx;
  int          test_errors;
  int          total_errors;
  int          tests_passed;

  rv_core i_dut (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .pc         (pc),
    .store_addr (store_addr),
    .store_data (store_data),
    .store_we   (store_we),
    .halt       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // instruction memory answers in the same cycle, ecall past the end
  assign fetch_idx = int'(pc[31:2]);

  always_comb begin
    if (!serving) begin
      insn = nop_word;
    end else if (fetch_idx < prog_len[cur_test]) begin
      insn = prog[cur_test][fetch_idx];
    end else begin
      insn = ecall_word;
    end
  end

  always @(posedge clk) begin
    if (!rst && serving && (store_we != 4'b0000)) begin
      cap_addr.push_back(store_addr);
      cap_we.push_back(store_we);
      cap_data.push_back(store_data);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // RV32I result for funct3, alt picks sub or sra
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? (a - b) : (a + b);
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  `include "rv_core_programs.svh"

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s: expected %h, actual %h", test_name[cur_test], what,
               expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error in %s: %s", test_name[cur_test], msg);
    test_errors++;
  endtask

  task automatic run_test(input int t);
    int          cycles;
    int          n;
    logic [31:0] halt_pc;
    test_errors = 0;
    @(posedge clk);
    #1;
    rst      = 1'b1;
    serving  = 1'b0;
    cur_test = t;
    repeat (5) @(posedge clk);
    #1;
    cap_addr.delete();
    cap_we.delete();
    cap_data.delete();
    rst     = 1'b0;
    serving = 1'b1;
    cycles  = 0;
    while (!halt && (cycles < timeout_cyc)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halt) begin
      report_error("halt did not rise within the timeout");
    end else begin
      halt_pc = pc;
      check_value("halt pc", 32'(exp_halt[t]), halt_pc);
      repeat (10) begin
        @(posedge clk);
        #1;
        check_value("pc while halted", halt_pc, pc);
      end
    end
    n = cap_addr.size();
    if (n != exp_count[t]) begin
      report_error($sformatf("expected %0d stores but saw %0d", exp_count[t], n));
    end
    for (int i = 0; (i < n) && (i < exp_count[t]); i++) begin
      check_value($sformatf("store %0d addr", i), exp_addr[t][i], cap_addr[i]);
      check_value($sformatf("store %0d strobe", i), {28'd0, exp_we[t][i]}, {28'd0, cap_we[i]});
      check_value($sformatf("store %0d data", i), exp_data[t][i], cap_data[i]);
    end
    total_errors += test_errors;
    if (test_errors == 0) begin
      tests_passed++;
    end
    $display("test %0d %s: %s", t, test_name[t], (test_errors == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    rst          = 1'b1;
    num_tests    = 0;
    total_errors = 0;
    tests_passed = 0;
    rng_state    = 32'had56_5276;
    build_programs();
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d passed, %0d errors", num_tests, tests_passed, total_errors);
    if (total_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
+incdir+verification
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_pc_unit.sv
hdl/rv_core.sv
verification/rv_core_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := rv_core_tb
RTL_TOP    := rv_core
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Done: no errors
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --timescale 1ns/1ps -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
